// File: sdram_macros.svh
`ifndef SDRAM_MACROS_SVH
`define SDRAM_MACROS_SVH

// CPU address and data widths
`define SDRAM_AW 24
`define SDRAM_DW 16

// SDRAM address pins and bank select
`define SDRAM_ROW_W 13
`define SDRAM_BA_W 2

// Sync strobes between periodic refresh demands
`define SDRAM_REFRESH_INTERVAL 64

// Sync strobes spent in the REFRESH state
`define SDRAM_REFRESH_SYNCS 4

// Word index width of the behavioral array (bank, row[1:0], col[7:0])
`define SDRAM_MODEL_IDX_W 12

`endif

// File: sdram_pkg.sv
`default_nettype none

`include "sdram_macros.svh"

package sdram_pkg;

    // Controller FSM states
    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_ACTIVATE  = 3'd1,
        ST_READ      = 3'd2,
        ST_WRITE     = 3'd3,
        ST_PRECHARGE = 3'd4,
        ST_REFRESH   = 3'd5
    } ctrl_state_t;

    // Command pins packed as {cs, ras, cas, we}, all active low
    typedef enum logic [3:0] {
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010,
        CMD_REFRESH   = 4'b0001
    } sdram_cmd_t;

    // One CPU access as held by the request latch
    typedef struct packed {
        logic                  is_write;
        logic [`SDRAM_AW-1:0]  addr;
        logic [`SDRAM_DW-1:0]  wdata;
        logic [1:0]            ds;
    } sdram_req_t;

endpackage

`default_nettype wire

// File: sdram_cmd_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdram_macros.svh"

interface sdram_cmd_if;
    import sdram_pkg::*;

    // Command, bank and address pins
    sdram_cmd_t                cmd;
    logic [`SDRAM_BA_W-1:0]    ba;
    logic [`SDRAM_ROW_W-1:0]   a;
    // Byte masks, high means masked
    logic [1:0]                dqm;
    // Split data paths, no tristate
    logic [`SDRAM_DW-1:0]      wdata;
    logic [`SDRAM_DW-1:0]      rdata;

    // Controller side
    modport ctrl (output cmd, ba, a, dqm, wdata, input rdata);

    // Memory side
    modport mem (input cmd, ba, a, dqm, wdata, output rdata);

endinterface

`default_nettype wire

// File: sdram_req_latch.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdram_macros.svh"

module sdram_req_latch (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   init,
    input  wire                   oe,
    input  wire                   we,
    input  wire [`SDRAM_AW-1:0]   addr,
    input  wire [`SDRAM_DW-1:0]   din,
    input  wire [1:0]             ds,
    input  wire                   take,
    output logic                  pending,
    output sdram_pkg::sdram_req_t req
);
    import sdram_pkg::*;

    logic       full;
    sdram_req_t held;
    sdram_req_t live;

    // Live CPU request, read wins over write
    always_comb begin
        live.is_write = we & ~oe;
        live.addr     = addr;
        live.wdata    = din;
        live.ds       = ds;
    end

    // Occupancy flag
    always_ff @(posedge clk) begin
        if (!rst_n || init) begin
            full <= 1'b0;
        end else if (take) begin
            // Controller consumed held or live request
            full <= 1'b0;
        end else if (!full && (oe || we)) begin
            full <= 1'b1;
        end
    end

    // Payload capture only while empty
    always_ff @(posedge clk) begin
        if (!full && (oe || we)) begin
            held <= live;
        end
    end

    // Empty latch passes the live request straight through
    assign pending = full | oe | we;
    assign req     = full ? held : live;

endmodule

`default_nettype wire

// File: sdram_refresh_timer.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdram_macros.svh"

module sdram_refresh_timer (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  init,
    input  wire  sync,
    input  wire  refresh,
    input  wire  refresh_done,
    output logic refresh_due
);
    localparam int CNT_W = $clog2(`SDRAM_REFRESH_INTERVAL);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (!rst_n || init) begin
            count       <= '0;
            refresh_due <= 1'b0;
        end else if (refresh_done) begin
            // Served, start a fresh interval
            count       <= '0;
            refresh_due <= 1'b0;
        end else begin
            // External request sets the demand directly
            if (refresh) begin
                refresh_due <= 1'b1;
            end
            // Count sync strobes while no demand is outstanding
            if (sync && !refresh_due) begin
                if (count == CNT_W'(`SDRAM_REFRESH_INTERVAL - 1)) begin
                    count       <= '0;
                    refresh_due <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sdram_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdram_macros.svh"

module sdram_ctrl (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   init,
    input  wire                   sync,
    input  wire                   pending,
    input  sdram_pkg::sdram_req_t req,
    output logic                  take,
    input  wire                   refresh_due,
    output logic                  refresh_done,
    sdram_cmd_if.ctrl             bus,
    output logic [`SDRAM_DW-1:0]  dout
);
    import sdram_pkg::*;

    localparam int CNT_W = $clog2(`SDRAM_REFRESH_SYNCS);

    ctrl_state_t          state;
    logic [CNT_W-1:0]     cnt;
    sdram_req_t           req_r;
    logic [`SDRAM_DW-1:0] dout_r;

    // Accept a request at a sync edge in IDLE
    assign take = sync & (state == ST_IDLE) & pending;

    // Refresh only when no request is waiting
    assign refresh_done = sync & (state == ST_IDLE) & ~pending & refresh_due;

    // Control state and command pins
    always_ff @(posedge clk) begin
        if (!rst_n || init) begin
            state   <= ST_IDLE;
            cnt     <= '0;
            bus.cmd <= CMD_NOP;
            bus.dqm <= 2'b11;
            dout_r  <= '0;
        end else begin
            // Each command is on the bus for exactly one clock
            bus.cmd <= CMD_NOP;
            bus.dqm <= 2'b11;

            if (sync) begin
                case (state)
                    ST_IDLE: begin
                        if (pending) begin
                            // Open the row of the accepted request
                            bus.cmd <= CMD_ACTIVE;
                            state   <= ST_ACTIVATE;
                        end else if (refresh_due) begin
                            bus.cmd <= CMD_REFRESH;
                            cnt     <= '0;
                            state   <= ST_REFRESH;
                        end
                    end
                    ST_ACTIVATE: begin
                        if (req_r.is_write) begin
                            // Masked bytes are the unselected ones
                            bus.cmd <= CMD_WRITE;
                            bus.dqm <= ~req_r.ds;
                            cnt     <= '0;
                            state   <= ST_WRITE;
                        end else begin
                            bus.cmd <= CMD_READ;
                            bus.dqm <= 2'b00;
                            state   <= ST_READ;
                        end
                    end
                    ST_READ: begin
                        // Zero CAS latency, data already valid
                        dout_r <= bus.rdata;
                        state  <= ST_PRECHARGE;
                    end
                    ST_WRITE: begin
                        // Two syncs of write recovery
                        cnt <= cnt + 1'b1;
                        if (cnt == CNT_W'(1)) begin
                            state <= ST_PRECHARGE;
                        end
                    end
                    ST_PRECHARGE: begin
                        bus.cmd <= CMD_PRECHARGE;
                        state   <= ST_IDLE;
                    end
                    ST_REFRESH: begin
                        cnt <= cnt + 1'b1;
                        if (cnt == CNT_W'(`SDRAM_REFRESH_SYNCS - 1)) begin
                            state <= ST_IDLE;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // Request copy, bank, address and write data pins
    always_ff @(posedge clk) begin
        if (sync) begin
            if (state == ST_IDLE && pending) begin
                req_r     <= req;
                bus.ba    <= req.addr[23:22];
                // Row is addr[21:10], top pin unused
                bus.a     <= {1'b0, req.addr[21:10]};
            end else if (state == ST_ACTIVATE) begin
                bus.a     <= {3'b000, req_r.addr[9:0]};
                bus.wdata <= req_r.wdata;
            end else if (state == ST_PRECHARGE) begin
                // A10 high selects all banks
                bus.a     <= `SDRAM_ROW_W'(13'h0400);
            end
        end
    end

    assign dout = dout_r;

endmodule

`default_nettype wire

// File: sdram_array_model.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdram_macros.svh"

module sdram_array_model (
    input  wire      clk,
    sdram_cmd_if.mem bus
);
    import sdram_pkg::*;

    localparam int DEPTH = 1 << `SDRAM_MODEL_IDX_W;

    logic [`SDRAM_DW-1:0]          mem [0:DEPTH-1];
    // Only the low two row bits reach the index
    logic [1:0]                    open_row [0:3];
    logic [`SDRAM_MODEL_IDX_W-1:0] wr_idx;
    logic [`SDRAM_MODEL_IDX_W-1:0] rd_idx;

    // Word index of the column command on the bus
    assign wr_idx = {bus.ba, open_row[bus.ba], bus.a[7:0]};

    always_ff @(posedge clk) begin
        case (bus.cmd)
            CMD_ACTIVE: begin
                open_row[bus.ba] <= bus.a[1:0];
            end
            CMD_WRITE: begin
                // dqm low enables the byte lane
                if (!bus.dqm[0]) begin
                    mem[wr_idx][7:0] <= bus.wdata[7:0];
                end
                if (!bus.dqm[1]) begin
                    mem[wr_idx][15:8] <= bus.wdata[15:8];
                end
            end
            CMD_READ: begin
                rd_idx <= wr_idx;
            end
            default: begin
            end
        endcase
    end

    // Word of the last READ, visible right after the command
    assign bus.rdata = mem[rd_idx];

endmodule

`default_nettype wire

// File: sdram_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdram_macros.svh"

module sdram_top (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  init,
    input  wire                  sync,
    input  wire                  oe,
    input  wire                  we,
    input  wire                  refresh,
    input  wire [`SDRAM_AW-1:0]  addr,
    input  wire [`SDRAM_DW-1:0]  din,
    input  wire [1:0]            ds,
    output logic [`SDRAM_DW-1:0] dout
);
    import sdram_pkg::*;

    logic       pending;
    logic       take;
    sdram_req_t req;
    logic       refresh_due;
    logic       refresh_done;

    // Controller to array command bus
    sdram_cmd_if cmd_bus ();

    sdram_req_latch u_latch (
        .clk     (clk),
        .rst_n   (rst_n),
        .init    (init),
        .oe      (oe),
        .we      (we),
        .addr    (addr),
        .din     (din),
        .ds      (ds),
        .take    (take),
        .pending (pending),
        .req     (req)
    );

    sdram_refresh_timer u_timer (
        .clk          (clk),
        .rst_n        (rst_n),
        .init         (init),
        .sync         (sync),
        .refresh      (refresh),
        .refresh_done (refresh_done),
        .refresh_due  (refresh_due)
    );

    sdram_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .init         (init),
        .sync         (sync),
        .pending      (pending),
        .req          (req),
        .take         (take),
        .refresh_due  (refresh_due),
        .refresh_done (refresh_done),
        .bus          (cmd_bus.ctrl),
        .dout         (dout)
    );

    // Behavioral memory, not reset by init
    sdram_array_model u_model (
        .clk (clk),
        .bus (cmd_bus.mem)
    );

endmodule

`default_nettype wire

// File: tb_sdram.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdram_macros.svh"

module tb_sdram;

    localparam int DEPTH = 1 << `SDRAM_MODEL_IDX_W;

    logic                 clk;
    logic                 rst_n;
    logic                 init;
    logic                 sync;
    logic                 oe;
    logic                 we;
    logic                 refresh;
    logic [`SDRAM_AW-1:0] addr;
    logic [`SDRAM_DW-1:0] din;
    logic [1:0]           ds;
    logic [`SDRAM_DW-1:0] dout;

    // Expected array contents by model index
    logic [`SDRAM_DW-1:0] sb_data [0:DEPTH-1];
    logic                 sb_used [0:DEPTH-1];
    logic [`SDRAM_AW-1:0] rnd_addr [0:19];
    logic [`SDRAM_DW-1:0] last_exp;
    logic [31:0]          lfsr;
    int                   errors;
    int                   checks;

    sdram_top UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .init    (init),
        .sync    (sync),
        .oe      (oe),
        .we      (we),
        .refresh (refresh),
        .addr    (addr),
        .din     (din),
        .ds      (ds),
        .dout    (dout)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // One sync clock in every four
    task automatic gen_sync();
        forever begin
            @(negedge clk);
            sync = 1'b1;
            @(negedge clk);
            sync = 1'b0;
            repeat (2) @(negedge clk);
        end
    endtask

    initial begin
        sync = 1'b0;
        gen_sync();
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // Bank, low row bits and low column bits select the model word
    function automatic logic [`SDRAM_MODEL_IDX_W-1:0] model_index(input logic [23:0] a);
        return {a[23:22], a[11:10], a[7:0]};
    endfunction

    // ds bit 1 selects the high byte, bit 0 the low byte
    function automatic logic [15:0] merge_bytes(input logic [15:0] old_w,
                                                input logic [15:0] wr_w,
                                                input logic [1:0]  strobes);
        return {strobes[1] ? wr_w[15:8] : old_w[15:8], strobes[0] ? wr_w[7:0] : old_w[7:0]};
    endfunction

    // Count sync strobes at rising edges, then settle on a falling edge
    task automatic wait_syncs(input int n);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < n && cycles < 4 * n + 8) begin
            @(posedge clk);
            cycles++;
            if (sync) begin
                seen++;
            end
        end
        if (seen < n) begin
            $display("Timeout at %0t: only %0d of %0d sync strobes arrived", $time, seen, n);
            errors++;
        end
        @(negedge clk);
    endtask

    task automatic check_dout(input logic [15:0] exp, input string what);
        checks++;
        assert (dout === exp) else begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, what, exp, dout);
            errors++;
        end
    endtask

    task automatic write_word(input logic [23:0] a, input logic [15:0] d,
                              input logic [1:0] strobes);
        logic [`SDRAM_MODEL_IDX_W-1:0] idx;
        idx  = model_index(a);
        addr = a;
        din  = d;
        ds   = strobes;
        we   = 1'b1;
        @(negedge clk);
        we = 1'b0;
        sb_data[idx] = merge_bytes(sb_data[idx], d, strobes);
        sb_used[idx] = 1'b1;
        // ACTIVE, WRITE, two recovery syncs and PRECHARGE
        wait_syncs(5);
    endtask

    task automatic read_word(input logic [23:0] a);
        logic [15:0] exp;
        exp  = sb_data[model_index(a)];
        addr = a;
        oe   = 1'b1;
        @(negedge clk);
        oe = 1'b0;
        wait_syncs(4);
        check_dout(exp, $sformatf("read of %h", a));
        last_exp = exp;
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("%s finished with %0d errors", name, errors - errs_before);
    endtask

    task automatic basic_write_read();
        int e0;
        e0 = errors;
        check_dout(16'h0000, "dout after reset");
        write_word(24'h00_0010, 16'hbeef, 2'b11);
        read_word(24'h00_0010);
        report_test("basic write and read", e0);
    endtask

    task automatic byte_strobe_merge();
        int e0;
        e0 = errors;
        write_word(24'h40_0421, 16'h1234, 2'b11);
        write_word(24'hc0_0c33, 16'habcd, 2'b11);
        // Low byte only, then high byte only
        write_word(24'h40_0421, 16'h5678, 2'b01);
        write_word(24'hc0_0c33, 16'h9876, 2'b10);
        read_word(24'h40_0421);
        read_word(24'hc0_0c33);
        report_test("byte strobes", e0);
    endtask

    task automatic random_sweep();
        int          e0;
        int          tries;
        logic [31:0] r;
        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            // Draw until the model index is still free
            tries = 0;
            r     = next_bits(24);
            while (sb_used[model_index(r[23:0])] && tries < 100) begin
                r = next_bits(24);
                tries++;
            end
            rnd_addr[i] = r[23:0];
            r = next_bits(16);
            write_word(rnd_addr[i], r[15:0], 2'b11);
        end
        // 7 is coprime to 20 so every address comes back once
        for (int i = 0; i < 20; i++) begin
            read_word(rnd_addr[(i * 7) % 20]);
        end
        report_test("random addresses", e0);
    endtask

    task automatic held_request_read();
        int e0;
        e0 = errors;
        write_word(24'h80_0855, last_exp ^ 16'h5a5a, 2'b11);
        // oe pulse ends one clock before the next sync
        repeat (2) @(negedge clk);
        read_word(24'h80_0855);
        report_test("request held between syncs", e0);
    endtask

    task automatic refresh_then_read();
        int          e0;
        int          n;
        logic        hit;
        logic [23:0] a;
        logic [15:0] exp;
        e0 = errors;
        // Drop the timer demand so only the refresh input can start one
        init = 1'b1;
        @(negedge clk);
        init = 1'b0;
        a  = 24'h3f_f3ee;
        write_word(a, last_exp ^ 16'h3c3c, 2'b11);
        exp      = sb_data[model_index(a)];
        refresh  = 1'b1;
        @(negedge clk);
        refresh = 1'b0;
        // Idle sync with no request takes the refresh
        wait_syncs(1);
        addr = a;
        oe   = 1'b1;
        @(negedge clk);
        oe  = 1'b0;
        n   = 0;
        hit = 1'b0;
        while (!hit && n < 20) begin
            wait_syncs(1);
            n++;
            hit = (dout === exp);
        end
        checks++;
        assert (hit) else begin
            $display("Read after refresh never returned the written word within 20 syncs");
            errors++;
        end
        checks++;
        assert (!hit || n >= `SDRAM_REFRESH_SYNCS + 3) else begin
            $display("ERROR at %0t: read data arrived after %0d syncs, refresh skipped", $time, n);
            errors++;
        end
        last_exp = exp;
        report_test("refresh then read", e0);
    endtask

    task automatic long_run_with_init();
        int e0;
        e0 = errors;
        // Nine idle syncs make a 13-sync read period, and timer demands
        // 65 syncs apart then land early in a gap, clear of the next read
        for (int i = 0; i < 16; i++) begin
            read_word(rnd_addr[(i * 3) % 20]);
            wait_syncs(9);
        end
        init = 1'b1;
        @(negedge clk);
        init = 1'b0;
        check_dout(16'h0000, "dout after init");
        read_word(24'hc0_0c33);
        read_word(rnd_addr[5]);
        report_test("refresh interval and init", e0);
    endtask

    initial begin
        rst_n    = 1'b0;
        init     = 1'b0;
        oe       = 1'b0;
        we       = 1'b0;
        refresh  = 1'b0;
        addr     = '0;
        din      = '0;
        ds       = 2'b00;
        lfsr     = 32'hfd5f;
        last_exp = '0;
        errors   = 0;
        checks   = 0;
        for (int i = 0; i < DEPTH; i++) begin
            sb_data[i] = '0;
            sb_used[i] = 1'b0;
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        // Start every request just after a sync
        wait_syncs(1);
        basic_write_read();
        byte_strobe_merge();
        random_sweep();
        held_request_read();
        refresh_then_read();
        long_run_with_init();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
sdram_pkg.sv
sdram_cmd_if.sv
sdram_req_latch.sv
sdram_refresh_timer.sv
sdram_ctrl.sv
sdram_array_model.sv
sdram_top.sv
tb_sdram.sv

// File: run_sim.sh
#!/bin/bash
# Build the SDRAM testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_sdram -o sim_sdram \
    && ./obj_dir/sim_sdram > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0
